/* list.f */
+incdir+source
source/exec_types_pkg.sv
source/mem_bus_pkg.sv
source/alu.sv
source/lane_align.sv
source/branch_resolve.sv
source/exec_unit.sv
source/exec_stage.sv
verification/mem_model.sv
verification/exec_checker.sv
verification/exec_tb.sv

/* run.sh */
#!/bin/bash
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module exec_tb -o exec_sim

# the run passes only if the pass line shows up in the output
./obj_dir/exec_sim | tee /dev/stderr | grep -x '\*\* PASS \*\*' > /dev/null

echo "simulation passed"

/* source/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module alu (
  input  logic [`EXEC_XLEN-1:0]      a,
  input  logic [`EXEC_XLEN-1:0]      b,
  input  exec_types_pkg::alu_op_e    op,
  output logic [`EXEC_XLEN-1:0]      result
);

  import exec_types_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // rv32i shifts only look at the low five bits
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = a + b;
    endcase
  end

endmodule

`default_nettype wire

/* source/branch_resolve.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module branch_resolve (
  input  exec_types_pkg::jump_kind_e jump,
  input  logic [`EXEC_XLEN-1:0]      pc,
  input  logic [`EXEC_XLEN-1:0]      val_a,
  input  logic [`EXEC_XLEN-1:0]      imm,
  input  logic [`EXEC_XLEN-1:0]      alu_result,
  output logic                       taken,
  output logic                       mispredict,
  output logic [`EXEC_XLEN-1:0]      target
);

  import exec_types_pkg::*;

  logic                  predicted;
  logic                  is_branch;
  logic [`EXEC_XLEN-1:0] base;
  logic [`EXEC_XLEN-1:0] sum;

  always_comb begin
    case (jump)
      JMP_JAL, JMP_JALR: taken = 1'b1;
      JMP_BNZ:           taken = |alu_result;
      JMP_BZ:            taken = ~|alu_result;
      default:           taken = 1'b0;
    endcase
  end

  // backward taken, forward not taken, jumps never predicted
  assign is_branch  = (jump == JMP_BNZ) || (jump == JMP_BZ);
  assign predicted  = is_branch & imm[`EXEC_XLEN-1];
  assign mispredict = taken ^ predicted;

  assign base   = (jump == JMP_JALR) ? val_a : pc;
  assign sum    = base + (taken ? imm : 'd4);
  assign target = {sum[`EXEC_XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

/* source/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// register word and register index
`define EXEC_XLEN 32
`define EXEC_REG_W 5

// memory side, one beat per transfer
`define EXEC_ADDR_W 32
`define EXEC_BUS_W 64
`define EXEC_STRB_W (`EXEC_BUS_W / 8)

`endif

/* source/exec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_stage (
  input  logic                       clock,
  input  logic                       reset,
  input  exec_types_pkg::exec_op_t   op,
  input  logic                       op_valid,
  output logic                       op_ready,
  output exec_types_pkg::wb_t        wb,
  output logic                       wb_valid,
  input  logic                       wb_ready,
  output mem_bus_pkg::rd_req_t       rd_req,
  input  mem_bus_pkg::rd_resp_t      rd_resp,
  output mem_bus_pkg::wr_req_t       wr_req,
  input  mem_bus_pkg::wr_resp_t      wr_resp,
  output logic                       flush,
  output logic [`EXEC_XLEN-1:0]      flush_pc,
  output logic [`EXEC_REG_W-1:0]     fwd_rd,
  output logic [`EXEC_XLEN-1:0]      fwd_data
);

  // decode, writeback and bus bridge attach here
  exec_unit u_exec_unit (
    .clock    (clock),
    .reset    (reset),
    .op       (op),
    .op_valid (op_valid),
    .op_ready (op_ready),
    .wb       (wb),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .rd_req   (rd_req),
    .rd_resp  (rd_resp),
    .wr_req   (wr_req),
    .wr_resp  (wr_resp),
    .flush    (flush),
    .flush_pc (flush_pc),
    .fwd_rd   (fwd_rd),
    .fwd_data (fwd_data)
  );

endmodule

`default_nettype wire

/* source/exec_types_pkg.sv */
`default_nettype none

`include "exec_cfg.svh"

package exec_types_pkg;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // bit 3 marks a load, bit 2 a store or a signed load
  typedef enum logic [3:0] {
    LS_NONE = 4'b0000,
    LS_LB   = 4'b1100,
    LS_LH   = 4'b1101,
    LS_LW   = 4'b1110,
    LS_LBU  = 4'b1000,
    LS_LHU  = 4'b1001,
    LS_SB   = 4'b0100,
    LS_SH   = 4'b0101,
    LS_SW   = 4'b0110
  } ls_kind_e;

  typedef enum logic [2:0] {
    JMP_NONE, JMP_JAL, JMP_JALR, JMP_BNZ, JMP_BZ
  } jump_kind_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_HOLD,
    ST_LOAD_REQ, ST_LOAD_RESP,
    ST_STORE_REQ, ST_STORE_ADDR, ST_STORE_DATA, ST_STORE_RESP
  } exec_state_e;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0]  pc;
    logic [`EXEC_XLEN-1:0]  val_a;
    logic [`EXEC_XLEN-1:0]  val_b;
    // branch offset, or store data
    logic [`EXEC_XLEN-1:0]  imm;
    logic                   use_pc;
    alu_op_e                alu_op;
    logic [`EXEC_REG_W-1:0] rd;
    logic                   link;
    ls_kind_e               ls;
    jump_kind_e             jump;
  } exec_op_t;

  typedef struct packed {
    logic [`EXEC_REG_W-1:0] rd;
    logic [`EXEC_XLEN-1:0]  data;
  } wb_t;

endpackage

`default_nettype wire

/* source/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  exec_types_pkg::exec_op_t   op,
  input  logic                       op_valid,
  output logic                       op_ready,
  output exec_types_pkg::wb_t        wb,
  output logic                       wb_valid,
  input  logic                       wb_ready,
  output mem_bus_pkg::rd_req_t       rd_req,
  input  mem_bus_pkg::rd_resp_t      rd_resp,
  output mem_bus_pkg::wr_req_t       wr_req,
  input  mem_bus_pkg::wr_resp_t      wr_resp,
  output logic                       flush,
  output logic [`EXEC_XLEN-1:0]      flush_pc,
  output logic [`EXEC_REG_W-1:0]     fwd_rd,
  output logic [`EXEC_XLEN-1:0]      fwd_data
);

  import exec_types_pkg::*;
  import mem_bus_pkg::*;

  exec_state_e state;
  exec_state_e state_next;
  exec_op_t    op_q;

  logic [`EXEC_XLEN-1:0]   load_q;
  logic [`EXEC_XLEN-1:0]   load_val;
  logic [`EXEC_XLEN-1:0]   alu_a;
  logic [`EXEC_XLEN-1:0]   alu_result;
  logic [`EXEC_XLEN-1:0]   wb_data;
  logic [`EXEC_REG_W-1:0]  wb_rd;
  logic [`EXEC_BUS_W-1:0]  st_wdata;
  logic [`EXEC_STRB_W-1:0] st_wstrb;
  logic [2:0]              xfer_size;
  logic                    mispredict;
  logic                    accept;
  logic                    load_take;
  logic                    op_is_load;
  logic                    op_is_store;
  logic                    q_is_load;
  logic                    q_is_store;

  assign op_is_load  = op.ls inside {LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU};
  assign op_is_store = op.ls inside {LS_SB, LS_SH, LS_SW};
  assign q_is_load   = op_q.ls inside {LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU};
  assign q_is_store  = op_q.ls inside {LS_SB, LS_SH, LS_SW};

  // next op can enter on the edge the current result leaves
  assign op_ready  = (state == ST_IDLE) || ((state == ST_HOLD) && wb_ready);
  assign accept    = op_valid & op_ready;
  assign load_take = (state == ST_LOAD_RESP) && rd_resp.rvalid;

  always_comb begin
    state_next = state;
    case (state)
      ST_HOLD: begin
        if (wb_ready) begin
          state_next = ST_IDLE;
        end
      end
      ST_LOAD_REQ: begin
        if (rd_resp.arready) begin
          state_next = ST_LOAD_RESP;
        end
      end
      ST_LOAD_RESP: begin
        if (rd_resp.rvalid) begin
          state_next = ST_HOLD;
        end
      end
      // address and data may finish in either order
      ST_STORE_REQ: begin
        if (wr_resp.awready && wr_resp.wready) begin
          state_next = ST_STORE_RESP;
        end else if (wr_resp.awready) begin
          state_next = ST_STORE_DATA;
        end else if (wr_resp.wready) begin
          state_next = ST_STORE_ADDR;
        end
      end
      ST_STORE_ADDR: begin
        if (wr_resp.awready) begin
          state_next = ST_STORE_RESP;
        end
      end
      ST_STORE_DATA: begin
        if (wr_resp.wready) begin
          state_next = ST_STORE_RESP;
        end
      end
      ST_STORE_RESP: begin
        if (wr_resp.bvalid) begin
          state_next = ST_HOLD;
        end
      end
      default: ;
    endcase

    if (accept) begin
      if (op_is_load) begin
        state_next = ST_LOAD_REQ;
      end else if (op_is_store) begin
        state_next = ST_STORE_REQ;
      end else begin
        state_next = ST_HOLD;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_q <= op;
    end
    if (load_take) begin
      load_q <= load_val;
    end
  end

  assign alu_a = op_q.use_pc ? op_q.pc : op_q.val_a;

  alu u_alu (
    .a      (alu_a),
    .b      (op_q.val_b),
    .op     (op_q.alu_op),
    .result (alu_result)
  );

  lane_align u_lane_align (
    .addr_low  (alu_result[2:0]),
    .ls        (op_q.ls),
    .store_val (op_q.imm),
    .bus_rdata (rd_resp.rdata),
    .wdata     (st_wdata),
    .wstrb     (st_wstrb),
    .size      (xfer_size),
    .load_val  (load_val)
  );

  branch_resolve u_branch_resolve (
    .jump       (op_q.jump),
    .pc         (op_q.pc),
    .val_a      (op_q.val_a),
    .imm        (op_q.imm),
    .alu_result (alu_result),
    .taken      (),
    .mispredict (mispredict),
    .target     (flush_pc)
  );

  // address comes from the alu adder
  always_comb begin
    rd_req.arvalid = (state == ST_LOAD_REQ);
    rd_req.araddr  = alu_result;
    rd_req.arsize  = xfer_size;
    rd_req.rready  = (state == ST_LOAD_RESP);
  end

  always_comb begin
    wr_req.awvalid = (state == ST_STORE_REQ) || (state == ST_STORE_ADDR);
    wr_req.awaddr  = alu_result;
    wr_req.awsize  = xfer_size;
    wr_req.wvalid  = (state == ST_STORE_REQ) || (state == ST_STORE_DATA);
    wr_req.wdata   = st_wdata;
    wr_req.wstrb   = st_wstrb;
    wr_req.bready  = (state == ST_STORE_RESP);
  end

  assign wb_data = q_is_load ? load_q : op_q.link ? op_q.pc + 'd4 : alu_result;
  // stores write back nothing
  assign wb_rd   = q_is_store ? '0 : op_q.rd;

  assign wb       = '{rd: wb_rd, data: wb_data};
  assign wb_valid = (state == ST_HOLD);
  assign flush    = mispredict & (state == ST_HOLD);

  assign fwd_rd   = (state != ST_IDLE) ? wb_rd : '0;
  assign fwd_data = wb_data;

endmodule

`default_nettype wire

/* source/lane_align.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module lane_align (
  input  logic [2:0]                addr_low,
  input  exec_types_pkg::ls_kind_e  ls,
  input  logic [`EXEC_XLEN-1:0]     store_val,
  input  logic [`EXEC_BUS_W-1:0]    bus_rdata,
  output logic [`EXEC_BUS_W-1:0]    wdata,
  output logic [`EXEC_STRB_W-1:0]   wstrb,
  output logic [2:0]                size,
  output logic [`EXEC_XLEN-1:0]     load_val
);

  import exec_types_pkg::*;

  logic [`EXEC_STRB_W-1:0] lane_mask;
  logic [`EXEC_BUS_W-1:0]  rd_lane;
  logic                    is_store;

  assign is_store = ls inside {LS_SB, LS_SH, LS_SW};

  // log2 of the byte count, as on the bus
  always_comb begin
    case (ls)
      LS_LB, LS_LBU, LS_SB: size = 3'd0;
      LS_LH, LS_LHU, LS_SH: size = 3'd1;
      default:              size = 3'd2;
    endcase
  end

  always_comb begin
    case (size)
      3'd0:    lane_mask = 'h1;
      3'd1:    lane_mask = 'h3;
      default: lane_mask = 'hf;
    endcase
  end

  assign wdata = {{(`EXEC_BUS_W-`EXEC_XLEN){1'b0}}, store_val} << {addr_low, 3'b000};
  assign wstrb = is_store ? lane_mask << addr_low : '0;

  // selected lane moves down to bit 0
  assign rd_lane = bus_rdata >> {addr_low, 3'b000};

  always_comb begin
    case (ls)
      LS_LB:   load_val = {{(`EXEC_XLEN-8){rd_lane[7]}}, rd_lane[7:0]};
      LS_LBU:  load_val = {{(`EXEC_XLEN-8){1'b0}}, rd_lane[7:0]};
      LS_LH:   load_val = {{(`EXEC_XLEN-16){rd_lane[15]}}, rd_lane[15:0]};
      LS_LHU:  load_val = {{(`EXEC_XLEN-16){1'b0}}, rd_lane[15:0]};
      default: load_val = rd_lane[`EXEC_XLEN-1:0];
    endcase
  end

endmodule

`default_nettype wire

/* source/mem_bus_pkg.sv */
`default_nettype none

`include "exec_cfg.svh"

package mem_bus_pkg;

  // read address and read data, master side
  typedef struct packed {
    logic                   arvalid;
    logic [`EXEC_ADDR_W-1:0] araddr;
    logic [2:0]             arsize;
    logic                   rready;
  } rd_req_t;

  typedef struct packed {
    logic                  arready;
    logic                  rvalid;
    logic [`EXEC_BUS_W-1:0] rdata;
  } rd_resp_t;

  // write address, write data and write response, master side
  typedef struct packed {
    logic                    awvalid;
    logic [`EXEC_ADDR_W-1:0]  awaddr;
    logic [2:0]              awsize;
    logic                    wvalid;
    logic [`EXEC_BUS_W-1:0]   wdata;
    logic [`EXEC_STRB_W-1:0]  wstrb;
    logic                    bready;
  } wr_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
  } wr_resp_t;

endpackage

`default_nettype wire

/* verification/exec_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_checker (
  input logic                        clock,
  input logic                        reset,
  input logic                        op_ready,
  input exec_types_pkg::wb_t         wb,
  input logic                        wb_valid,
  input logic                        wb_ready,
  input logic                        flush,
  input mem_bus_pkg::rd_req_t        rd_req,
  input mem_bus_pkg::rd_resp_t       rd_resp,
  input mem_bus_pkg::wr_req_t        wr_req,
  input mem_bus_pkg::wr_resp_t       wr_resp
);

  import mem_bus_pkg::*;

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    rd_req.arvalid && !rd_resp.arready |=> rd_req.arvalid && $stable(rd_req.araddr))
    else $error("arvalid or araddr changed before arready");

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    wr_req.awvalid && !wr_resp.awready |=> wr_req.awvalid && $stable(wr_req.awaddr))
    else $error("awvalid or awaddr changed before awready");

  wb_hold: assert property (@(posedge clock) disable iff (reset)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb))
    else $error("writeback changed under back-pressure");

  flush_with_wb: assert property (@(posedge clock) disable iff (reset)
    flush |-> wb_valid)
    else $error("flush high without wb_valid");

  // no new operation while a bus transfer is open
  busy_not_ready: assert property (@(posedge clock) disable iff (reset)
    rd_req.arvalid || rd_req.rready || wr_req.awvalid || wr_req.wvalid || wr_req.bready
    |-> !op_ready)
    else $error("op_ready high during a memory access");

endmodule

bind exec_unit exec_checker u_exec_checker (
  .clock    (clock),
  .reset    (reset),
  .op_ready (op_ready),
  .wb       (wb),
  .wb_valid (wb_valid),
  .wb_ready (wb_ready),
  .flush    (flush),
  .rd_req   (rd_req),
  .rd_resp  (rd_resp),
  .wr_req   (wr_req),
  .wr_resp  (wr_resp)
);

`default_nettype wire

/* verification/exec_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_tb;

  import exec_types_pkg::*;
  import mem_bus_pkg::*;

  localparam int WAIT_LIMIT = 100;

  typedef struct packed {
    exec_op_t               op;
    logic [`EXEC_XLEN-1:0]  data;
    logic [`EXEC_REG_W-1:0] rd;
    logic                   flush;
    logic [`EXEC_XLEN-1:0]  flush_pc;
  } entry_t;

  logic                   clock;
  logic                   reset;
  exec_op_t               op;
  logic                   op_valid;
  logic                   op_ready;
  wb_t                    wb;
  logic                   wb_valid;
  logic                   wb_ready;
  rd_req_t                rd_req;
  rd_resp_t               rd_resp;
  wr_req_t                wr_req;
  wr_resp_t               wr_resp;
  logic                   flush;
  logic [`EXEC_XLEN-1:0]  flush_pc;
  logic [`EXEC_REG_W-1:0] fwd_rd;
  logic [`EXEC_XLEN-1:0]  fwd_data;

  entry_t     table_q[$];
  // expected memory contents, follows the stores in the table
  logic [7:0] shadow [0:255];
  int         errors;
  int         results = 0;
  bit         timed_out;

  exec_stage u_exec_stage (.*);
  mem_model u_mem_model (.*);

  always #4 clock = ~clock;

  // writeback handshakes seen at the DUT boundary
  always @(posedge clock) begin
    if (wb_valid && wb_ready) begin
      results <= results + 1;
    end
  end

  task automatic check(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("Error: %s is %h, expected %h at %0t", name, got, expected, $time);
    end
  endtask

  function automatic exec_op_t make_op(logic [31:0] pc, logic [31:0] a, logic [31:0] b,
                                       logic [31:0] imm, alu_op_e alu_op, logic [4:0] rd,
                                       ls_kind_e ls, jump_kind_e jump);
    exec_op_t o;
    o = '0;
    o.pc     = pc;
    o.val_a  = a;
    o.val_b  = b;
    o.imm    = imm;
    o.alu_op = alu_op;
    o.rd     = rd;
    o.ls     = ls;
    o.jump   = jump;
    o.link   = (jump == JMP_JAL) || (jump == JMP_JALR);
    return o;
  endfunction

  function automatic void add_entry(exec_op_t o, logic [31:0] data, logic [4:0] rd,
                                    logic fl, logic [31:0] fpc);
    entry_t e;
    e.op       = o;
    e.data     = data;
    e.rd       = rd;
    e.flush    = fl;
    e.flush_pc = fpc;
    table_q.push_back(e);
  endfunction

  // fixed operands: a is negative, b gives a shift of 3
  function automatic void add_alu(alu_op_e alu_op, logic [31:0] expected, logic [4:0] rd);
    add_entry(make_op(32'h1000, 32'hF0000005, 32'h00000023, 32'h0, alu_op, rd, LS_NONE,
                      JMP_NONE), expected, rd, 1'b0, 32'h0);
  endfunction

  // a store writes back its address with rd zero
  function automatic void add_store(ls_kind_e kind, logic [7:0] addr, logic [31:0] value);
    int n;
    n = (kind == LS_SB) ? 1 : (kind == LS_SH) ? 2 : 4;
    for (int k = 0; k < n; k++) begin
      shadow[addr + 8'(k)] = value[8*k +: 8];
    end
    add_entry(make_op(32'h2000, 32'h0, {24'h0, addr}, value, ALU_ADD, 5'd7, kind, JMP_NONE),
              {24'h0, addr}, 5'd0, 1'b0, 32'h0);
  endfunction

  function automatic void add_load(ls_kind_e kind, logic [7:0] addr, logic [4:0] rd);
    logic [31:0] word;
    logic [31:0] expected;
    word = {shadow[addr + 8'd3], shadow[addr + 8'd2], shadow[addr + 8'd1], shadow[addr]};
    case (kind)
      LS_LB:   expected = {{24{word[7]}}, word[7:0]};
      LS_LBU:  expected = {24'h0, word[7:0]};
      LS_LH:   expected = {{16{word[15]}}, word[15:0]};
      LS_LHU:  expected = {16'h0, word[15:0]};
      default: expected = word;
    endcase
    add_entry(make_op(32'h2400, 32'h0, {24'h0, addr}, 32'h0, ALU_ADD, rd, kind, JMP_NONE),
              expected, rd, 1'b0, 32'h0);
  endfunction

  function automatic void build_table();
    for (int i = 0; i < 256; i++) begin
      shadow[i] = 8'(i);
    end
    add_alu(ALU_ADD, 32'hF0000028, 5'd1);
    add_alu(ALU_SUB, 32'hEFFFFFE2, 5'd2);
    add_alu(ALU_SLL, 32'h80000028, 5'd3);
    add_alu(ALU_SLT, 32'h00000001, 5'd4);
    add_alu(ALU_SLTU, 32'h00000000, 5'd5);
    add_alu(ALU_XOR, 32'hF0000026, 5'd6);
    add_alu(ALU_SRL, 32'h1E000000, 5'd7);
    add_alu(ALU_SRA, 32'hFE000000, 5'd8);
    add_alu(ALU_OR, 32'hF0000027, 5'd9);
    add_alu(ALU_AND, 32'h00000001, 5'd10);
    // stores at every lane, read back whole words
    for (int k = 0; k < 8; k++) begin
      add_store(LS_SB, 8'h40 + 8'(k), 32'h5A5A5AA0 + 32'(k));
    end
    add_load(LS_LW, 8'h40, 5'd11);
    add_load(LS_LW, 8'h44, 5'd12);
    for (int k = 0; k < 4; k++) begin
      add_store(LS_SH, 8'h48 + 8'(2 * k), 32'h7777C100 + 32'(k));
    end
    add_load(LS_LW, 8'h48, 5'd13);
    add_load(LS_LW, 8'h4C, 5'd14);
    add_store(LS_SW, 8'h50, 32'h8899AABB);
    add_store(LS_SW, 8'h54, 32'h11223344);
    for (int k = 0; k < 8; k++) begin
      add_load(LS_LBU, 8'h50 + 8'(k), 5'(16 + k));
    end
    // bytes with bit 7 set
    add_load(LS_LB, 8'h85, 5'd24);
    add_load(LS_LH, 8'h86, 5'd25);
    add_load(LS_LBU, 8'h93, 5'd26);
    add_load(LS_LHU, 8'h9A, 5'd27);
    add_entry(make_op(32'h100, 32'h0, 32'h0, 32'h40, ALU_ADD, 5'd1, LS_NONE, JMP_JAL),
              32'h104, 5'd1, 1'b1, 32'h140);
    add_entry(make_op(32'h200, 32'h303, 32'h0, 32'h10, ALU_ADD, 5'd2, LS_NONE, JMP_JALR),
              32'h204, 5'd2, 1'b1, 32'h312);
    add_entry(make_op(32'h3000, 32'h5, 32'h3, 32'hFFFFFFF0, ALU_SUB, 5'd0, LS_NONE, JMP_BNZ),
              32'h2, 5'd0, 1'b0, 32'h0);
    add_entry(make_op(32'h3010, 32'h5, 32'h5, 32'hFFFFFFF0, ALU_SUB, 5'd0, LS_NONE, JMP_BNZ),
              32'h0, 5'd0, 1'b1, 32'h3014);
    add_entry(make_op(32'h3020, 32'h9, 32'h9, 32'h20, ALU_SUB, 5'd0, LS_NONE, JMP_BZ),
              32'h0, 5'd0, 1'b1, 32'h3040);
  endfunction

  task automatic run_entry(int idx);
    entry_t e;
    int     n;
    int     stall;
    e = table_q[idx];
    @(negedge clock);
    op       = e.op;
    op_valid = 1'b1;
    n = 0;
    while (!op_ready && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!op_ready) begin
      $display("timeout: operation %0d was never accepted", idx);
      errors++;
      timed_out = 1'b1;
      return;
    end
    // taken on the rising edge in between
    @(negedge clock);
    op_valid = 1'b0;
    n = 0;
    while (!wb_valid && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!wb_valid) begin
      $display("timeout: no writeback for operation %0d", idx);
      errors++;
      timed_out = 1'b1;
      return;
    end
    stall = $urandom_range(2, 0);
    repeat (stall) begin
      check("fwd_rd", 32'(fwd_rd), 32'(e.rd));
      @(negedge clock);
    end
    check("wb_valid", 32'(wb_valid), 32'h1);
    check("wb.rd", 32'(wb.rd), 32'(e.rd));
    check("wb.data", wb.data, e.data);
    check("fwd_rd", 32'(fwd_rd), 32'(e.rd));
    check("fwd_data", fwd_data, e.data);
    check("flush", 32'(flush), 32'(e.flush));
    if (e.flush) begin
      check("flush_pc", flush_pc, e.flush_pc);
    end
    wb_ready = 1'b1;
    @(negedge clock);
    wb_ready = 1'b0;
    // the result leaves exactly once
    check("wb_valid", 32'(wb_valid), 32'h0);
    check("fwd_rd", 32'(fwd_rd), 32'h0);
  endtask

  initial begin
    void'($urandom(32'h6725dffe));
    clock     = 1'b0;
    reset     = 1'b1;
    op        = '0;
    op_valid  = 1'b0;
    wb_ready  = 1'b0;
    errors    = 0;
    timed_out = 1'b0;
    build_table();
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check("op_ready", 32'(op_ready), 32'h1);
    check("wb_valid", 32'(wb_valid), 32'h0);
    check("flush", 32'(flush), 32'h0);
    foreach (table_q[i]) begin
      if (!timed_out) begin
        run_entry(i);
      end
    end
    check("result count", results, table_q.size());
    $display("results: %0d of %0d, errors: %0d", results, table_q.size(), errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module mem_model (
  input  logic                  clock,
  input  logic                  reset,
  input  mem_bus_pkg::rd_req_t  rd_req,
  output mem_bus_pkg::rd_resp_t rd_resp,
  input  mem_bus_pkg::wr_req_t  wr_req,
  output mem_bus_pkg::wr_resp_t wr_resp
);

  import mem_bus_pkg::*;

  // 32 words of 8 bytes, 256 bytes in all
  logic [`EXEC_BUS_W-1:0]  mem [0:31];
  logic [1:0]              ar_cnt;
  logic [1:0]              r_cnt;
  logic [1:0]              aw_cnt;
  logic [1:0]              w_cnt;
  logic [1:0]              b_cnt;
  logic                    r_busy;
  logic                    aw_got;
  logic                    w_got;
  logic                    b_busy;
  logic [4:0]              r_word;
  logic [4:0]              aw_word;
  logic [`EXEC_BUS_W-1:0]  w_data;
  logic [`EXEC_STRB_W-1:0] w_strb;

  // every byte holds the low byte of its own address
  initial begin
    for (int w = 0; w < 32; w++) begin
      for (int k = 0; k < 8; k++) begin
        mem[w][8*k +: 8] = 8'(w * 8 + k);
      end
    end
  end

  // a ready or valid shows once its counter has run down
  always_comb begin
    rd_resp.arready = rd_req.arvalid && (ar_cnt == 2'd0);
    rd_resp.rvalid  = r_busy && (r_cnt == 2'd0);
    rd_resp.rdata   = mem[r_word];
    wr_resp.awready = wr_req.awvalid && (aw_cnt == 2'd0);
    wr_resp.wready  = wr_req.wvalid && (w_cnt == 2'd0);
    wr_resp.bvalid  = b_busy && (b_cnt == 2'd0);
  end

  always @(posedge clock) begin
    if (reset) begin
      ar_cnt <= 2'd0;
      r_cnt  <= 2'd0;
      aw_cnt <= 2'd0;
      w_cnt  <= 2'd0;
      b_cnt  <= 2'd0;
      r_busy <= 1'b0;
      aw_got <= 1'b0;
      w_got  <= 1'b0;
      b_busy <= 1'b0;
    end else begin
      if (rd_resp.arready) begin
        r_busy <= 1'b1;
        r_word <= rd_req.araddr[7:3];
        r_cnt  <= 2'($urandom);
        ar_cnt <= 2'($urandom);
      end else if (rd_req.arvalid && ar_cnt != 2'd0) begin
        ar_cnt <= ar_cnt - 2'd1;
      end
      if (rd_resp.rvalid && rd_req.rready) begin
        r_busy <= 1'b0;
      end else if (r_busy && r_cnt != 2'd0) begin
        r_cnt <= r_cnt - 2'd1;
      end

      if (wr_resp.awready) begin
        aw_got  <= 1'b1;
        aw_word <= wr_req.awaddr[7:3];
        aw_cnt  <= 2'($urandom);
      end else if (wr_req.awvalid && aw_cnt != 2'd0) begin
        aw_cnt <= aw_cnt - 2'd1;
      end
      if (wr_resp.wready) begin
        w_got  <= 1'b1;
        w_data <= wr_req.wdata;
        w_strb <= wr_req.wstrb;
        w_cnt  <= 2'($urandom);
      end else if (wr_req.wvalid && w_cnt != 2'd0) begin
        w_cnt <= w_cnt - 2'd1;
      end

      // write once both address and data are in
      if (aw_got && w_got) begin
        for (int k = 0; k < 8; k++) begin
          if (w_strb[k]) begin
            mem[aw_word][8*k +: 8] <= w_data[8*k +: 8];
          end
        end
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_busy <= 1'b1;
        b_cnt  <= 2'($urandom);
      end
      if (wr_resp.bvalid && wr_req.bready) begin
        b_busy <= 1'b0;
      end else if (b_busy && b_cnt != 2'd0) begin
        b_cnt <= b_cnt - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire
